// ==== source/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

`define DC_ADDR_W     32
`define DC_WORD_W     32
`define DC_STRB_W     4

// two ways, 16 sets of 4-word lines
`define DC_LINE_WORDS 4
`define DC_LINE_W     128
`define DC_SETS       16

// address split: tag | index | word | byte
`define DC_OFFSET_W   4
`define DC_INDEX_W    4
`define DC_TAG_W      24

`endif

// ==== source/dcache_pkg.sv ====
`include "dcache_defs.svh"

package dcache_pkg;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] index;
        logic [1:0]             word_sel;
        logic [1:0]             byte_off;
    } addr_fields_t;

    // same 32 bits, seen flat by the bus side and split by the cache side
    typedef union packed {
        logic [`DC_ADDR_W-1:0] flat;
        addr_fields_t          f;
    } addr_u;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic                  uncached;
        addr_u                 addr;
        logic [`DC_WORD_W-1:0] wdata;
        logic [`DC_STRB_W-1:0] wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic                  busy;
        logic                  rvalid;
        logic [`DC_WORD_W-1:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic                  req;
        logic                  write;
        logic                  line;   // 1: full line, 0: single word
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_LINE_W-1:0] wdata;
        logic [`DC_STRB_W-1:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic                  rdy;
        logic                  ret_valid;
        logic [`DC_LINE_W-1:0] rdata;
    } mem_resp_t;

endpackage

// ==== source/dcache_store.sv ====
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_store (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [`DC_INDEX_W-1:0]           rd_index,
    input  logic [`DC_INDEX_W-1:0]           wr_index,
    input  logic [1:0]                       way_we,
    input  logic [`DC_LINE_WORDS-1:0]        word_we,
    input  logic [`DC_LINE_W-1:0]            line_wdata,
    input  logic [`DC_TAG_W-1:0]             tag_wdata,
    input  logic                             set_dirty,
    input  logic                             lru_update,
    input  logic                             lru_way,
    output logic [1:0][`DC_TAG_W-1:0]        tags,
    output logic [1:0]                       valids,
    output logic [1:0]                       dirtys,
    output logic [1:0][`DC_LINE_W-1:0]       lines,
    output logic                             lru
);

    logic [`DC_TAG_W-1:0]  tag_mem  [0:1][0:`DC_SETS-1];
    logic [`DC_LINE_W-1:0] data_mem [0:1][0:`DC_SETS-1];
    logic [1:0][`DC_SETS-1:0] valid_q;
    logic [1:0][`DC_SETS-1:0] dirty_q;
    logic [`DC_SETS-1:0]      lru_q;   // way to evict next

    // tag and data arrays
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way_we[w]) begin
                for (int i = 0; i < `DC_LINE_WORDS; i++) begin
                    if (word_we[i])
                        data_mem[w][wr_index][i*`DC_WORD_W +: `DC_WORD_W] <=
                            line_wdata[i*`DC_WORD_W +: `DC_WORD_W];
                end
                if (!set_dirty)
                    tag_mem[w][wr_index] <= tag_wdata;   // refill brings a new tag
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (way_we[w]) begin
                    if (set_dirty) begin
                        dirty_q[w][wr_index] <= 1'b1;
                    end else begin
                        valid_q[w][wr_index] <= 1'b1;
                        dirty_q[w][wr_index] <= 1'b0;
                    end
                end
            end
            if (lru_update)
                lru_q[wr_index] <= ~lru_way;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            tags[w]   <= tag_mem[w][rd_index];
            lines[w]  <= data_mem[w][rd_index];
            valids[w] <= valid_q[w][rd_index];
            dirtys[w] <= dirty_q[w][rd_index];
        end
        // a hit and the next lookup to the same set can land on one edge
        if (lru_update && wr_index == rd_index)
            lru <= ~lru_way;
        else
            lru <= lru_q[rd_index];
    end

endmodule

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                             clk,
    input  logic                             reset,
    input  dcache_pkg::cpu_req_t             cpu_req,
    output logic                             busy,
    output logic                             rvalid,
    output logic [`DC_WORD_W-1:0]            rdata,
    output logic [`DC_INDEX_W-1:0]           rd_index,
    output logic [`DC_INDEX_W-1:0]           wr_index,
    output logic [1:0]                       way_we,
    output logic [`DC_LINE_WORDS-1:0]        word_we,
    output logic [`DC_LINE_W-1:0]            line_wdata,
    output logic [`DC_TAG_W-1:0]             tag_wdata,
    output logic                             set_dirty,
    output logic                             lru_update,
    output logic                             lru_way,
    input  logic [1:0][`DC_TAG_W-1:0]        tags,
    input  logic [1:0]                       valids,
    input  logic [1:0]                       dirtys,
    input  logic [1:0][`DC_LINE_W-1:0]       lines,
    input  logic                             lru,
    output dcache_pkg::mem_req_t             mem_req,
    input  dcache_pkg::mem_resp_t            mem_resp
);

    localparam logic [2:0] S_LOOKUP  = 3'd0,
                           S_WB_REQ  = 3'd1,
                           S_WB_WAIT = 3'd2,
                           S_RF_REQ  = 3'd3,
                           S_RF_WAIT = 3'd4,
                           S_RF_DONE = 3'd5;

    logic [2:0]            state;
    dcache_pkg::cpu_req_t  req_q;
    logic                  req_valid;
    logic                  victim;
    logic                  accept;
    logic [1:0]            hit_way;
    logic                  hit;
    logic                  hit_sel;
    logic                  lookup_hit;
    logic                  refill_we;
    logic [1:0]            wsel;
    logic [`DC_WORD_W-1:0] hit_word;
    logic [`DC_WORD_W-1:0] merged;

    assign accept = cpu_req.valid & ~cpu_req.uncached;   // valid is already gated by busy
    assign wsel   = req_q.addr.f.word_sel;

    assign hit_way[0] = valids[0] & (tags[0] == req_q.addr.f.tag);
    assign hit_way[1] = valids[1] & (tags[1] == req_q.addr.f.tag);
    assign hit        = |hit_way;
    assign hit_sel    = hit_way[1];
    assign hit_word   = lines[hit_sel][wsel*`DC_WORD_W +: `DC_WORD_W];
    assign lookup_hit = req_valid & (state == S_LOOKUP) & hit;

    assign rvalid = lookup_hit & ~req_q.write;
    assign rdata  = hit_word;
    assign busy   = req_valid & ~(lookup_hit & ~req_q.write);

    always_comb begin
        for (int b = 0; b < `DC_STRB_W; b++)
            merged[b*8 +: 8] = req_q.wstrb[b] ? req_q.wdata[b*8 +: 8] : hit_word[b*8 +: 8];
    end

    // store-side write port
    assign refill_we  = (state == S_RF_WAIT) & mem_resp.ret_valid;
    assign rd_index   = accept ? cpu_req.addr.f.index : req_q.addr.f.index;
    assign wr_index   = req_q.addr.f.index;
    assign tag_wdata  = req_q.addr.f.tag;
    assign set_dirty  = ~refill_we;
    assign lru_update = lookup_hit;
    assign lru_way    = hit_sel;
    assign line_wdata = refill_we ? mem_resp.rdata : {`DC_LINE_WORDS{merged}};

    always_comb begin
        way_we  = 2'b00;
        word_we = '0;
        if (refill_we) begin
            way_we[victim] = 1'b1;
            word_we        = '1;
        end else if (lookup_hit && req_q.write) begin
            way_we        = hit_way;
            word_we[wsel] = 1'b1;
        end
    end

    always_comb begin
        mem_req       = '0;
        mem_req.req   = (state == S_WB_REQ) | (state == S_RF_REQ);
        mem_req.write = (state == S_WB_REQ);
        mem_req.line  = 1'b1;
        mem_req.addr  = {(state == S_WB_REQ) ? tags[victim] : req_q.addr.f.tag,
                         req_q.addr.f.index, {`DC_OFFSET_W{1'b0}}};
        mem_req.wdata = lines[victim];   // store keeps re-reading this set
        mem_req.wstrb = '1;
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= cpu_req;
        if (state == S_LOOKUP && req_valid && !hit)
            victim <= lru;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            state     <= S_LOOKUP;
        end else begin
            if (accept)
                req_valid <= 1'b1;
            else if (lookup_hit)
                req_valid <= 1'b0;
            case (state)
                S_LOOKUP:
                    if (req_valid && !hit)
                        state <= (valids[lru] & dirtys[lru]) ? S_WB_REQ : S_RF_REQ;
                S_WB_REQ:  if (mem_resp.rdy) state <= S_WB_WAIT;
                S_WB_WAIT: if (mem_resp.ret_valid) state <= S_RF_REQ;
                S_RF_REQ:  if (mem_resp.rdy) state <= S_RF_WAIT;
                S_RF_WAIT: if (mem_resp.ret_valid) state <= S_RF_DONE;
                S_RF_DONE: state <= S_LOOKUP;   // re-read the set, then hit
                default:   state <= S_LOOKUP;
            endcase
        end
    end

endmodule

// ==== source/uncached_port.sv ====
`timescale 1ns/1ns
`include "dcache_defs.svh"

module uncached_port (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output logic                  busy,
    output logic                  rvalid,
    output logic [`DC_WORD_W-1:0] rdata,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp
);

    localparam logic [1:0] L_IDLE = 2'd0,
                           L_REQ  = 2'd1,
                           L_WAIT = 2'd2,
                           L_DONE = 2'd3;

    logic [1:0]            ld_state;
    logic                  ld_busy;
    logic                  sb_valid;
    logic                  sb_wait;   // store granted, waiting for the ack
    logic [`DC_ADDR_W-1:0] sb_addr;
    logic [`DC_WORD_W-1:0] sb_wdata;
    logic [`DC_STRB_W-1:0] sb_wstrb;
    logic [`DC_ADDR_W-1:0] ld_addr;
    logic [`DC_WORD_W-1:0] ld_rdata;
    logic                  unc_store;
    logic                  acc_store;
    logic                  acc_load;

    assign ld_busy   = (ld_state == L_REQ) | (ld_state == L_WAIT);
    assign unc_store = cpu_req.valid & cpu_req.uncached & cpu_req.write;
    assign busy      = ld_busy | (unc_store & sb_valid);   // hold a store while buffer full
    assign acc_store = unc_store & ~busy;
    assign acc_load  = cpu_req.valid & cpu_req.uncached & ~cpu_req.write & ~busy;
    assign rvalid    = (ld_state == L_DONE);
    assign rdata     = ld_rdata;

    always_comb begin
        mem_req = '0;
        if (sb_valid && !sb_wait) begin
            mem_req.req   = 1'b1;
            mem_req.write = 1'b1;
            mem_req.addr  = {sb_addr[`DC_ADDR_W-1:2], 2'b00};
            mem_req.wstrb = sb_wstrb;
            mem_req.wdata[`DC_WORD_W-1:0] = sb_wdata;
        end else if (ld_state == L_REQ && !sb_valid) begin
            mem_req.req  = 1'b1;
            mem_req.addr = {ld_addr[`DC_ADDR_W-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (acc_store) begin
            sb_addr  <= cpu_req.addr.flat;
            sb_wdata <= cpu_req.wdata;
            sb_wstrb <= cpu_req.wstrb;
        end
        if (acc_load)
            ld_addr <= cpu_req.addr.flat;
        if (ld_state == L_WAIT && mem_resp.ret_valid)
            ld_rdata <= mem_resp.rdata[`DC_WORD_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sb_valid <= 1'b0;
            sb_wait  <= 1'b0;
            ld_state <= L_IDLE;
        end else begin
            if (acc_store)
                sb_valid <= 1'b1;
            else if (sb_wait && mem_resp.ret_valid)
                sb_valid <= 1'b0;
            if (sb_valid && !sb_wait && mem_resp.rdy)
                sb_wait <= 1'b1;
            else if (sb_wait && mem_resp.ret_valid)
                sb_wait <= 1'b0;
            case (ld_state)
                L_REQ:   if (!sb_valid && mem_resp.rdy) ld_state <= L_WAIT;
                L_WAIT:  if (mem_resp.ret_valid) ld_state <= L_DONE;
                default: ld_state <= acc_load ? L_REQ : L_IDLE;   // idle or done
            endcase
        end
    end

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::mem_req_t  cache_req,
    output dcache_pkg::mem_resp_t cache_resp,
    input  dcache_pkg::mem_req_t  unc_req,
    output dcache_pkg::mem_resp_t unc_resp,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp
);

    logic locked;
    logic owner_unc;
    logic sel_unc;

    // idle bus grants at once, uncached side first
    assign sel_unc = locked ? owner_unc : unc_req.req;
    assign mem_req = sel_unc ? unc_req : cache_req;

    always_comb begin
        unc_resp             = mem_resp;
        unc_resp.rdy         = mem_resp.rdy & sel_unc;
        unc_resp.ret_valid   = mem_resp.ret_valid & sel_unc;
        cache_resp           = mem_resp;
        cache_resp.rdy       = mem_resp.rdy & ~sel_unc;
        cache_resp.ret_valid = mem_resp.ret_valid & ~sel_unc;
    end

    // hold the owner from first request to ret_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            locked    <= 1'b0;
            owner_unc <= 1'b0;
        end else if (!locked && mem_req.req) begin
            locked    <= 1'b1;
            owner_unc <= sel_unc;
        end else if (locked && mem_resp.ret_valid) begin
            locked <= 1'b0;
        end
    end

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output dcache_pkg::cpu_resp_t cpu_resp,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp
);

    dcache_pkg::cpu_req_t  ctrl_cpu_req;
    dcache_pkg::cpu_req_t  unc_cpu_req;
    dcache_pkg::mem_req_t  cache_mreq;
    dcache_pkg::mem_req_t  unc_mreq;
    dcache_pkg::mem_resp_t cache_mresp;
    dcache_pkg::mem_resp_t unc_mresp;

    logic                          ctrl_busy, unc_busy, busy_all;
    logic                          ctrl_rvalid, unc_rvalid;
    logic [`DC_WORD_W-1:0]         ctrl_rdata, unc_rdata;
    logic [`DC_INDEX_W-1:0]        rd_index, wr_index;
    logic [1:0]                    way_we;
    logic [`DC_LINE_WORDS-1:0]     word_we;
    logic [`DC_LINE_W-1:0]         line_wdata;
    logic [`DC_TAG_W-1:0]          tag_wdata;
    logic                          set_dirty, lru_update, lru_way, lru;
    logic [1:0][`DC_TAG_W-1:0]     tags;
    logic [1:0]                    valids, dirtys;
    logic [1:0][`DC_LINE_W-1:0]    lines;

    assign busy_all = ctrl_busy | unc_busy;

    // ctrl busy is registered only, so it can gate the uncached side first
    always_comb begin
        unc_cpu_req        = cpu_req;
        unc_cpu_req.valid  = cpu_req.valid & ~ctrl_busy;
        ctrl_cpu_req       = cpu_req;
        ctrl_cpu_req.valid = cpu_req.valid & ~busy_all;
    end

    assign cpu_resp.busy   = busy_all;
    assign cpu_resp.rvalid = ctrl_rvalid | unc_rvalid;
    assign cpu_resp.rdata  = unc_rvalid ? unc_rdata : ctrl_rdata;

    dcache_ctrl u_ctrl (
        .clk(clk), .reset(reset), .cpu_req(ctrl_cpu_req),
        .busy(ctrl_busy), .rvalid(ctrl_rvalid), .rdata(ctrl_rdata),
        .rd_index(rd_index), .wr_index(wr_index), .way_we(way_we), .word_we(word_we),
        .line_wdata(line_wdata), .tag_wdata(tag_wdata), .set_dirty(set_dirty),
        .lru_update(lru_update), .lru_way(lru_way), .tags(tags), .valids(valids),
        .dirtys(dirtys), .lines(lines), .lru(lru),
        .mem_req(cache_mreq), .mem_resp(cache_mresp)
    );

    dcache_store u_store (
        .clk(clk), .reset(reset), .rd_index(rd_index), .wr_index(wr_index),
        .way_we(way_we), .word_we(word_we), .line_wdata(line_wdata),
        .tag_wdata(tag_wdata), .set_dirty(set_dirty), .lru_update(lru_update),
        .lru_way(lru_way), .tags(tags), .valids(valids), .dirtys(dirtys),
        .lines(lines), .lru(lru)
    );

    uncached_port u_unc (
        .clk(clk), .reset(reset), .cpu_req(unc_cpu_req),
        .busy(unc_busy), .rvalid(unc_rvalid), .rdata(unc_rdata),
        .mem_req(unc_mreq), .mem_resp(unc_mresp)
    );

    mem_arbiter u_arb (
        .clk(clk), .reset(reset),
        .cache_req(cache_mreq), .cache_resp(cache_mresp),
        .unc_req(unc_mreq), .unc_resp(unc_mresp),
        .mem_req(mem_req), .mem_resp(mem_resp)
    );

endmodule

// ==== bench/tb_mem_model.sv ====
`timescale 1ns/1ns
`include "dcache_defs.svh"

module tb_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::mem_req_t  mem_req,
    output dcache_pkg::mem_resp_t mem_resp
);

    logic [7:0]  mem [0:4095];
    int          line_reads;
    int          line_writes;
    int          txn_seq;
    int          last_word_wr;   // txn number of the latest word write
    int          last_line_rd;
    logic [31:0] rng;
    logic [2:0]  state;
    logic [1:0]  cnt;
    logic [11:0] base;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        logic [31:0] r;
        logic [11:0] a;
        r = 32'h3400;
        for (int i = 0; i < 4096; i++) begin
            a = i[11:0];
            r = xorshift(r);
            mem[i] = r[7:0] ^ a[7:0] ^ {4'h0, a[11:8]};
        end
    end

    // idle, accept delay, rdy, return delay, ret_valid
    always @(posedge clk) begin
        if (reset) begin
            state        <= 3'd0;
            mem_resp     <= '0;
            rng           = 32'h3400;
            line_reads    = 0;
            line_writes   = 0;
            txn_seq       = 0;
            last_word_wr  = 0;
            last_line_rd  = 0;
        end else begin
            case (state)
                3'd0: if (mem_req.req) begin
                    rng = xorshift(rng);
                    cnt   <= rng[1:0];
                    state <= 3'd1;
                end
                3'd1: if (cnt == 2'd0) begin
                    mem_resp.rdy <= 1'b1;
                    state        <= 3'd2;
                end else begin
                    cnt <= cnt - 2'd1;
                end
                3'd2: begin
                    mem_resp.rdy <= 1'b0;
                    txn_seq = txn_seq + 1;
                    base = mem_req.addr[11:0];
                    if (mem_req.line) begin
                        base[3:0] = 4'h0;
                        if (mem_req.write) begin
                            for (int i = 0; i < 16; i++)
                                mem[base + i[11:0]] = mem_req.wdata[i*8 +: 8];
                            line_writes = line_writes + 1;
                        end else begin
                            for (int i = 0; i < 16; i++)
                                mem_resp.rdata[i*8 +: 8] <= mem[base + i[11:0]];
                            line_reads   = line_reads + 1;
                            last_line_rd = txn_seq;
                        end
                    end else begin
                        base[1:0] = 2'b00;
                        if (mem_req.write) begin
                            for (int b = 0; b < 4; b++)
                                if (mem_req.wstrb[b])
                                    mem[base + b[11:0]] = mem_req.wdata[b*8 +: 8];
                            last_word_wr = txn_seq;
                        end else begin
                            mem_resp.rdata <= {96'h0, mem[base + 12'd3], mem[base + 12'd2],
                                               mem[base + 12'd1], mem[base]};
                        end
                    end
                    rng = xorshift(rng);
                    cnt   <= rng[1:0];
                    state <= 3'd3;
                end
                3'd3: if (cnt == 2'd0) begin
                    mem_resp.ret_valid <= 1'b1;
                    state              <= 3'd4;
                end else begin
                    cnt <= cnt - 2'd1;
                end
                default: begin
                    mem_resp.ret_valid <= 1'b0;
                    state              <= 3'd0;
                end
            endcase
        end
    end

endmodule

// ==== bench/tb_dcache.sv ====
`timescale 1ns/1ns
`include "dcache_defs.svh"

module tb_dcache;

    localparam logic [2:0] OP_LD = 3'd0, OP_ST = 3'd1, OP_POKE = 3'd2,
                           OP_CHKMEM = 3'd3, OP_ORDER = 3'd4;

    typedef struct packed {
        logic [2:0]  op;
        logic        unc;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        exp_hit;
        logic [1:0]  exp_wb;   // line writes expected during the row
    } row_t;

    row_t                  rows[$];
    logic                  clk;
    logic                  reset;
    dcache_pkg::cpu_req_t  cpu_req;
    dcache_pkg::cpu_resp_t cpu_resp;
    dcache_pkg::mem_req_t  mem_req;
    dcache_pkg::mem_resp_t mem_resp;
    logic [7:0]            golden [0:4095];
    int                    cycles = 0;
    int                    limit = 0;

    dcache_top uut (
        .clk(clk), .reset(reset), .cpu_req(cpu_req), .cpu_resp(cpu_resp),
        .mem_req(mem_req), .mem_resp(mem_resp)
    );

    tb_mem_model mem_model (
        .clk(clk), .reset(reset), .mem_req(mem_req), .mem_resp(mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the cache stopped responding after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    task automatic add_row(input logic [2:0] op, input logic unc, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb,
                           input logic exp_hit, input logic [1:0] exp_wb);
        rows.push_back({op, unc, addr, wdata, strb, exp_hit, exp_wb});
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] golden_word(input logic [31:0] addr);
        logic [11:0] a;
        a = {addr[11:2], 2'b00};
        return {golden[a + 12'd3], golden[a + 12'd2], golden[a + 12'd1], golden[a]};
    endfunction

    task automatic golden_store(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [3:0] strb);
        logic [11:0] a;
        a = {addr[11:2], 2'b00};
        for (int b = 0; b < 4; b++)
            if (strb[b])
                golden[a + b[11:0]] = wdata[b*8 +: 8];
    endtask

    task automatic run_access(input row_t r);
        logic [31:0] exp;
        logic        exp_busy;
        logic        exp_rvalid;
        // state seen in the cycle after acceptance
        exp_busy   = (r.op == OP_LD) ? (r.unc || !r.exp_hit) : !r.unc;
        exp_rvalid = (r.op == OP_LD) && !r.unc && r.exp_hit;
        cpu_req.valid      = 1'b1;
        cpu_req.write      = (r.op == OP_ST);
        cpu_req.uncached   = r.unc;
        cpu_req.addr.flat  = r.addr;
        cpu_req.wdata      = r.wdata;
        cpu_req.wstrb      = r.strb;
        @(negedge clk);
        while (cpu_resp.busy)
            @(negedge clk);
        @(posedge clk);   // accepted here
        #5 cpu_req.valid = 1'b0;
        @(negedge clk);
        check_value("busy", cpu_resp.busy, exp_busy);
        check_value("rvalid", cpu_resp.rvalid, exp_rvalid);
        if (r.op == OP_ST) begin
            golden_store(r.addr, r.wdata, r.strb);
            while (cpu_resp.busy) begin
                @(negedge clk);
                check_value("rvalid", cpu_resp.rvalid, 0);
            end
        end else begin
            exp = golden_word(r.addr);
            while (!cpu_resp.rvalid)
                @(negedge clk);
            check_value("rdata", cpu_resp.rdata, exp);
            @(negedge clk);
            check_value("rvalid", cpu_resp.rvalid, 0);   // single-cycle pulse
        end
    endtask

    task automatic apply_row(input row_t r);
        int          rd0;
        int          wr0;
        logic [11:0] a;
        rd0 = mem_model.line_reads;
        wr0 = mem_model.line_writes;
        a   = r.addr[11:0];
        @(posedge clk);
        #5;
        case (r.op)
            OP_LD, OP_ST: begin
                run_access(r);
                check_value("line_reads", mem_model.line_reads - rd0,
                            (r.exp_hit || r.unc) ? 0 : 1);
                check_value("line_writes", mem_model.line_writes - wr0, r.exp_wb);
            end
            OP_POKE: begin
                a[1:0] = 2'b00;
                for (int b = 0; b < 4; b++) begin
                    mem_model.mem[a + b[11:0]] = r.wdata[b*8 +: 8];
                    golden[a + b[11:0]] = r.wdata[b*8 +: 8];
                end
            end
            OP_CHKMEM: begin
                a[3:0] = 4'h0;
                for (int i = 0; i < 16; i++)
                    check_value("mem_byte", mem_model.mem[a + i[11:0]], golden[a + i[11:0]]);
            end
            default: check_value("word_write_first",
                                 mem_model.last_line_rd - mem_model.last_word_wr, 1);
        endcase
    endtask

    initial begin
        cpu_req = '0;
        reset   = 1'b1;
        // op, uncached, address, data, strobe, hit, line writes
        add_row(OP_LD, 0, 32'h020, 32'h0, 4'h0, 0, 0);
        add_row(OP_LD, 0, 32'h024, 32'h0, 4'h0, 1, 0);
        add_row(OP_ST, 0, 32'h028, 32'hA5A55A5A, 4'b0101, 1, 0);
        add_row(OP_LD, 0, 32'h028, 32'h0, 4'h0, 1, 0);
        add_row(OP_LD, 0, 32'h014, 32'h0, 4'h0, 0, 0);     // A, set 1
        add_row(OP_LD, 0, 32'h114, 32'h0, 4'h0, 0, 0);     // B
        add_row(OP_LD, 0, 32'h018, 32'h0, 4'h0, 1, 0);
        add_row(OP_LD, 0, 32'h214, 32'h0, 4'h0, 0, 0);     // C evicts B
        add_row(OP_LD, 0, 32'h010, 32'h0, 4'h0, 1, 0);
        add_row(OP_ST, 0, 32'h030, 32'h12345678, 4'b1111, 0, 0);
        add_row(OP_ST, 0, 32'h13C, 32'h9ABCDEF0, 4'b1100, 0, 0);
        add_row(OP_LD, 0, 32'h230, 32'h0, 4'h0, 0, 1);     // dirty victim
        add_row(OP_CHKMEM, 0, 32'h030, 32'h0, 4'h0, 0, 0);
        add_row(OP_ST, 1, 32'h400, 32'hCAFEF00D, 4'b1111, 0, 0);
        add_row(OP_LD, 1, 32'h400, 32'h0, 4'h0, 0, 0);
        add_row(OP_POKE, 0, 32'h400, 32'h0BADBEEF, 4'h0, 0, 0);
        add_row(OP_LD, 1, 32'h400, 32'h0, 4'h0, 0, 0);
        add_row(OP_ST, 1, 32'h500, 32'h11223344, 4'b1111, 0, 0);
        add_row(OP_LD, 0, 32'h540, 32'h0, 4'h0, 0, 0);
        add_row(OP_ORDER, 0, 32'h0, 32'h0, 4'h0, 0, 0);
        limit = rows.size() * 80 + 40;

        repeat (10) @(posedge clk);
        #5 reset = 1'b0;
        check_value("busy", cpu_resp.busy, 0);
        check_value("rvalid", cpu_resp.rvalid, 0);
        check_value("mem_req.req", mem_req.req, 0);
        for (int i = 0; i < 4096; i++)
            golden[i] = mem_model.mem[i];

        foreach (rows[i])
            apply_row(rows[i]);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
source/dcache_pkg.sv
source/dcache_store.sv
source/dcache_ctrl.sv
source/uncached_port.sv
source/mem_arbiter.sv
source/dcache_top.sv
bench/tb_mem_model.sv
bench/tb_dcache.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_dcache
FILELIST  = build.f
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
